// ==== flist.f ====
rtl/ldpc_dims_pkg.sv
rtl/dmem_types_pkg.sv
rtl/dmem_delta_calc.sv
rtl/dmem_circ_queue.sv
rtl/dmem_srq_regout.sv
rtl/ldpc_dmem_top.sv
dv/ldpc_dmem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the D memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=ldpc_dmem_tb
OBJ=obj_dir
BIN=ldpc_dmem_sim
LOG=sim.log

# compile the file list into a simulation binary
verilator --binary --timing --timescale 1ns/1ps \
  -f flist.f --top-module "$TOP" -Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# run, keeping the whole output in the log
"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides the result
if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "no result line found in $LOG"
  exit 1
fi

exit 0

// ==== dv/ldpc_dmem_tb.sv ====
`timescale 1ns/1ps

module ldpc_dmem_tb;

  import ldpc_dims_pkg::*;
  import dmem_types_pkg::*;

  //////////////////////////////
  // run limits
  //////////////////////////////

  localparam int SEED        = 16020;
  // cycle budget of each test as an upper bound
  localparam int LEN_RESET   = 8;
  localparam int LEN_EMPTY   = 24;
  localparam int LEN_REMAP   = 12;
  localparam int LEN_SAT     = 12;
  localparam int LEN_AGEING  = 40;
  localparam int LEN_OVERLAP = 30;
  localparam int LEN_RANDOM  = 210;
  localparam int TIMEOUT_CYCLES = LEN_RESET + LEN_EMPTY + LEN_REMAP + LEN_SAT +
                                  LEN_AGEING + LEN_OVERLAP + LEN_RANDOM + 50;

  logic     clk;
  logic     rst;
  logic     i_valid;
  msg_bus_t i_new_msg;
  msg_bus_t i_old_msg;
  rd_req_t  i_rd;
  d_bus_t   o_rd_data;

  ldpc_dmem_top UUT (
    .clk       (clk),
    .rst       (rst),
    .i_valid   (i_valid),
    .i_new_msg (i_new_msg),
    .i_old_msg (i_old_msg),
    .i_rd      (i_rd),
    .o_rd_data (o_rd_data)
  );

  // counters
  int cycles;
  int err_count;
  int check_count;
  int test_num;
  int test_err_start;

  // reference model state in row-unit order
  d_bus_t m_queue [DEPTH];
  d_bus_t m_qout;
  logic   m_pend_wr;
  d_bus_t m_pend_d;
  // o_rd_data expected after the latest edge
  d_bus_t exp_bus;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // D = new - old clamped to -32 .. +31
  function automatic d_bus_t calc_d(input msg_bus_t new_m, input msg_bus_t old_m);
    d_bus_t res;
    int     diff;
    for (int i = 0; i < LANES; i++) begin
      diff = int'(new_m.lane[i]) - int'(old_m.lane[i]);
      if (diff > 31) begin
        diff = 31;
      end else if (diff < -32) begin
        diff = -32;
      end
      res.lane[i] = d_t'(diff);
    end
    return res;
  endfunction

  function automatic void model_reset();
    for (int i = 0; i < DEPTH; i++) begin
      m_queue[i] = '0;
    end
    m_qout    = '0;
    m_pend_wr = 1'b0;
    m_pend_d  = '0;
  endfunction

  // advance the model by one clock edge and return o_rd_data after it
  function automatic d_bus_t exp_read(input logic valid, input msg_bus_t new_m,
                                      input msg_bus_t old_m, input rd_req_t rd);
    d_bus_t res;
    int     idx;
    // output register takes what the queue read one edge ago
    res = m_qout;
    // read sees the queue before this edge's shift
    if (rd.en) begin
      idx    = int'(rd.layer) * SLOTS + int'(rd.addr);
      m_qout = m_queue[idx];
    end
    if (m_pend_wr) begin
      for (int i = DEPTH - 1; i > 0; i--) begin
        m_queue[i] = m_queue[i-1];
      end
      m_queue[0] = m_pend_d;
    end
    // delta stage delays the write by one edge
    m_pend_wr = valid;
    if (valid) begin
      m_pend_d = calc_d(new_m, old_m);
    end
    return res;
  endfunction

  always @(posedge clk) begin
    if (!rst) begin
      model_reset();
      exp_bus = '0;
    end else begin
      exp_bus = exp_read(i_valid, i_new_msg, i_old_msg, i_rd);
    end
  end

  //////////////////////////////
  // compare and timeout
  //////////////////////////////

  task automatic report_mismatch(input d_bus_t want, input d_bus_t got);
    err_count++;
    $display("error t=%0t o_rd_data exp=%h got=%h", $time, want, got);
  endtask

  // sample mid-cycle away from both edges
  always @(negedge clk) begin
    if (rst) begin
      check_count++;
      if (o_rd_data !== exp_bus) begin
        report_mismatch(exp_bus, o_rd_data);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // inputs change 1 ns after the edge and fall back to idle
  task automatic tick();
    @(posedge clk);
    #1;
    i_valid = 1'b0;
    i_rd.en = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  function automatic msg_bus_t rand_bus(input int lo, input int hi);
    msg_bus_t m;
    for (int i = 0; i < LANES; i++) begin
      m.lane[i] = msg_t'(int'($urandom_range(hi - lo)) + lo);
    end
    return m;
  endfunction

  task automatic write_msgs(input msg_bus_t new_m, input msg_bus_t old_m);
    i_valid   = 1'b1;
    i_new_msg = new_m;
    i_old_msg = old_m;
    tick();
  endtask

  // D of these stays inside -30 .. +30
  task automatic write_rand();
    write_msgs(rand_bus(-20, 20), rand_bus(-10, 10));
  endtask

  task automatic issue_read(input int layer, input int addr);
    i_rd.en    = 1'b1;
    i_rd.layer = 1'(layer);
    i_rd.addr  = ADDR_W'(addr);
  endtask

  // output is stable two edges after the request
  task automatic read_entry(input int layer, input int addr, output d_bus_t data);
    issue_read(layer, addr);
    tick();
    tick();
    data = o_rd_data;
  endtask

  task automatic start_test();
    test_num++;
    test_err_start = err_count;
  endtask

  // drain the read pipe so late mismatches land in this test
  task automatic end_test(input string name);
    idle(3);
    $display("test %0d %s: %0d errors", test_num, name, err_count - test_err_start);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    d_bus_t   got;
    d_bus_t   want;
    d_bus_t   a_d;
    d_bus_t   b_d;
    d_bus_t   c_d;
    d_bus_t   dropped;
    msg_bus_t nm;
    msg_bus_t om;
    int       n;
    int       o;
    int       w;
    void'($urandom(SEED));
    cycles = 0;
    err_count = 0;
    check_count = 0;
    test_num = 0;
    test_err_start = 0;
    rst = 1'b0;
    i_valid = 1'b0;
    i_new_msg = '0;
    i_old_msg = '0;
    i_rd = '0;
    repeat (LEN_RESET) @(posedge clk);
    #1;
    rst = 1'b1;

    // empty queue reads back zero everywhere
    start_test();
    for (int l = 0; l < LAYERS; l++) begin
      for (int a = 0; a < SLOTS; a++) begin
        read_entry(l, a, got);
        if (got !== '0) begin
          report_mismatch('0, got);
        end
      end
    end
    end_test("empty reads");

    // lane i carries D = i - 16 so no two lanes match
    start_test();
    om = '0;
    for (int i = 0; i < LANES; i++) begin
      nm.lane[i]   = msg_t'(i - 16);
      want.lane[i] = d_t'(i - 16);
    end
    write_msgs(nm, om);
    idle(1);
    read_entry(0, 0, got);
    if (got !== want) begin
      report_mismatch(want, got);
    end
    end_test("remap round trip");

    // six message pairs around both clamps
    start_test();
    for (int i = 0; i < LANES; i++) begin
      case (i % 6)
        0: begin
          n = 127;
          o = -128;
          w = 31;
        end
        1: begin
          n = -128;
          o = 127;
          w = -32;
        end
        2: begin
          n = 5;
          o = -7;
          w = 12;
        end
        3: begin
          n = -40;
          o = -30;
          w = -10;
        end
        4: begin
          n = 31;
          o = 0;
          w = 31;
        end
        default: begin
          n = -50;
          o = -17;
          w = -32;
        end
      endcase
      nm.lane[i]   = msg_t'(n);
      om.lane[i]   = msg_t'(o);
      want.lane[i] = d_t'(w);
    end
    write_msgs(nm, om);
    idle(1);
    read_entry(0, 0, got);
    if (got !== want) begin
      report_mismatch(want, got);
    end
    end_test("saturation");

    // an all +31 word that exactly DEPTH later writes push out
    start_test();
    repeat (3) write_rand();
    for (int i = 0; i < LANES; i++) begin
      nm.lane[i]      = msg_t'(127);
      om.lane[i]      = msg_t'(-128);
      dropped.lane[i] = d_t'(31);
    end
    write_msgs(nm, om);
    repeat (DEPTH) write_rand();
    idle(1);
    for (int l = 0; l < LAYERS; l++) begin
      for (int a = 0; a < SLOTS; a++) begin
        read_entry(l, a, got);
        if (got === dropped) begin
          err_count++;
          $display("a word written %0d writes ago is still readable at layer %0d addr %0d",
                   DEPTH, l, a);
        end
      end
    end
    end_test("queue ageing");

    // output holds while writes go on with no read
    start_test();
    om = '0;
    for (int i = 0; i < LANES; i++) begin
      nm.lane[i]  = msg_t'(25 - i);
      a_d.lane[i] = d_t'(25 - i);
    end
    write_msgs(nm, om);
    idle(1);
    read_entry(0, 0, got);
    if (got !== a_d) begin
      report_mismatch(a_d, got);
    end
    repeat (4) begin
      write_rand();
      if (o_rd_data !== a_d) begin
        report_mismatch(a_d, o_rd_data);
      end
    end
    for (int i = 0; i < LANES; i++) begin
      nm.lane[i]  = msg_t'((i % 20) - 10);
      b_d.lane[i] = d_t'((i % 20) - 10);
    end
    write_msgs(nm, om);
    idle(1);
    for (int i = 0; i < LANES; i++) begin
      nm.lane[i]  = msg_t'(((i * 3) % 40) - 20);
      c_d.lane[i] = d_t'(((i * 3) % 40) - 20);
    end
    // C lands on the same edge that takes this read so B comes back
    write_msgs(nm, om);
    read_entry(0, 0, got);
    if (got !== b_d) begin
      report_mismatch(b_d, got);
    end
    // three reads back to back return C then B then C
    issue_read(0, 0);
    tick();
    issue_read(0, 1);
    tick();
    if (o_rd_data !== c_d) begin
      report_mismatch(c_d, o_rd_data);
    end
    issue_read(0, 0);
    tick();
    if (o_rd_data !== b_d) begin
      report_mismatch(b_d, o_rd_data);
    end
    tick();
    if (o_rd_data !== c_d) begin
      report_mismatch(c_d, o_rd_data);
    end
    end_test("hold and overlap");

    // full message range makes clamps show up often
    start_test();
    for (int c = 0; c < 200; c++) begin
      if ($urandom_range(1) == 1) begin
        i_valid   = 1'b1;
        i_new_msg = rand_bus(-128, 127);
        i_old_msg = rand_bus(-128, 127);
      end
      if ($urandom_range(1) == 1) begin
        issue_read(int'($urandom_range(LAYERS - 1)), int'($urandom_range(SLOTS - 1)));
      end
      tick();
    end
    end_test("random mix");

    $display("tests %0d, cycle compares %0d, errors %0d", test_num, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/ldpc_dmem_top.sv ====
`timescale 1ns/1ps

module ldpc_dmem_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_valid,
  input  dmem_types_pkg::msg_bus_t i_new_msg,
  input  dmem_types_pkg::msg_bus_t i_old_msg,
  input  dmem_types_pkg::rd_req_t  i_rd,
  output dmem_types_pkg::d_bus_t   o_rd_data
);

  import dmem_types_pkg::*;

  //////////////////////////////
  // write path
  //////////////////////////////

  // registered strobe and D bus from the delta unit
  logic   wr_en;
  d_bus_t wr_data;

  // new - old per lane, saturated, one cycle
  dmem_delta_calc u_delta (
    .clk       (clk),
    .rst       (rst),
    .i_valid   (i_valid),
    .i_new_msg (i_new_msg),
    .i_old_msg (i_old_msg),
    .o_wr_en   (wr_en),
    .o_wr_data (wr_data)
  );

  //////////////////////////////
  // queue memory
  //////////////////////////////

  // reorder, NB queues, output register
  // two cycles from request to o_rd_data
  dmem_srq_regout u_dmem (
    .clk       (clk),
    .rst       (rst),
    .i_wr_en   (wr_en),
    .i_wr_data (wr_data),
    .i_rd      (i_rd),
    .o_rd_data (o_rd_data)
  );

endmodule

// ==== rtl/dmem_srq_regout.sv ====
`timescale 1ns/1ps

module dmem_srq_regout (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_wr_en,
  input  dmem_types_pkg::d_bus_t  i_wr_data,
  input  dmem_types_pkg::rd_req_t i_rd,
  output dmem_types_pkg::d_bus_t  o_rd_data
);

  import ldpc_dims_pkg::*;
  import dmem_types_pkg::*;

  // one write word and one read word per circulant block
  circ_word_t wr_word [NB];
  circ_word_t rd_word [NB];

  // gathered read data before the output register
  d_bus_t rd_bus;

  //////////////////////////////
  // scatter, row-unit to circ
  //////////////////////////////

  // row j, block b, weight k goes to lane k*P+j of queue b
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      for (int j = 0; j < P; j++) begin
        for (int k = 0; k < WT; k++) begin
          wr_word[b].lane[k*P + j] = i_wr_data.lane[j*NB*WT + b*WT + k];
        end
      end
    end
  end

  //////////////////////////////
  // queue per circulant
  //////////////////////////////

  // all queues share strobe and request
  // they only differ in data
  for (genvar b = 0; b < NB; b++) begin : g_circ
    dmem_circ_queue u_queue (
      .clk       (clk),
      .rst       (rst),
      .i_wr_en   (i_wr_en),
      .i_wr_data (wr_word[b]),
      .i_rd      (i_rd),
      .o_rd_data (rd_word[b])
    );
  end

  //////////////////////////////
  // gather, circ to row-unit
  //////////////////////////////

  // exact inverse of the scatter above
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      for (int j = 0; j < P; j++) begin
        for (int k = 0; k < WT; k++) begin
          rd_bus.lane[j*NB*WT + b*WT + k] = rd_word[b].lane[k*P + j];
        end
      end
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  // loaded every cycle, so it tracks the held queue outputs
  // second cycle of the read latency
  always_ff @(posedge clk) begin
    if (!rst) begin
      o_rd_data <= '0;
    end else begin
      o_rd_data <= rd_bus;
    end
  end

endmodule

// ==== rtl/dmem_circ_queue.sv ====
`timescale 1ns/1ps

module dmem_circ_queue (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_wr_en,
  input  dmem_types_pkg::circ_word_t i_wr_data,
  input  dmem_types_pkg::rd_req_t    i_rd,
  output dmem_types_pkg::circ_word_t o_rd_data
);

  import ldpc_dims_pkg::*;
  import dmem_types_pkg::*;

  //////////////////////////////
  // storage
  //////////////////////////////

  // entry 0 holds the newest write
  // entry DEPTH-1 the oldest
  circ_word_t q [DEPTH];

  // entry picked by the read request
  logic [IDX_W-1:0] rd_idx;

  // layer selects the upper or lower half of the queue
  assign rd_idx = (IDX_W'(i_rd.layer) * IDX_W'(SLOTS)) + IDX_W'(i_rd.addr);

  //////////////////////////////
  // shift on write
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        q[i] <= '0;
      end
    end else if (i_wr_en) begin
      // new word enters at the young end
      q[0] <= i_wr_data;
      // everything else ages by one place
      // last entry falls off the end
      for (int i = 1; i < DEPTH; i++) begin
        q[i] <= q[i-1];
      end
    end
  end

  //////////////////////////////
  // registered read
  //////////////////////////////

  // nonblocking update, so a read in a write cycle
  // picks the entry from before the shift
  always_ff @(posedge clk) begin
    if (!rst) begin
      o_rd_data <= '0;
    end else if (i_rd.en) begin
      o_rd_data <= q[rd_idx];
    end
  end

endmodule

// ==== rtl/dmem_delta_calc.sv ====
`timescale 1ns/1ps

module dmem_delta_calc (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_valid,
  input  dmem_types_pkg::msg_bus_t i_new_msg,
  input  dmem_types_pkg::msg_bus_t i_old_msg,
  output logic                     o_wr_en,
  output dmem_types_pkg::d_bus_t   o_wr_data
);

  import ldpc_dims_pkg::*;
  import dmem_types_pkg::*;

  //////////////////////////////
  // difference per lane
  //////////////////////////////

  // full precision new - old, one bit wider than a message
  logic signed [DIFF_W-1:0] diff [LANES];

  // saturated D for every lane, still in row-unit order
  d_bus_t d_next;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      // sign-extend both operands before the subtraction
      diff[i] = DIFF_W'(i_new_msg.lane[i]) - DIFF_W'(i_old_msg.lane[i]);
    end
  end

  //////////////////////////////
  // saturation to D_W bits
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      if (diff[i] > DIFF_W'(D_MAX)) begin
        // clamp at the top, +31
        d_next.lane[i] = D_W'(D_MAX);
      end else if (diff[i] < DIFF_W'(D_MIN)) begin
        // clamp at the bottom, -32
        d_next.lane[i] = D_W'(D_MIN);
      end else begin
        // in range, low bits are already the right value
        d_next.lane[i] = diff[i][D_W-1:0];
      end
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  // strobe follows i_valid by one cycle
  always_ff @(posedge clk) begin
    if (!rst) begin
      o_wr_en <= 1'b0;
    end else begin
      o_wr_en <= i_valid;
    end
  end

  // wide bus only moves on a valid cycle
  // idle cycles leave it quiet
  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_wr_data <= d_next;
    end
  end

endmodule

// ==== rtl/dmem_types_pkg.sv ====
package dmem_types_pkg;

  import ldpc_dims_pkg::*;

  //////////////////////////////
  // scalar lane types
  //////////////////////////////

  // one extrinsic message, two's complement
  typedef logic signed [MSG_W-1:0] msg_t;

  // one saturated D value
  typedef logic signed [D_W-1:0] d_t;

  //////////////////////////////
  // row-unit order buses
  //////////////////////////////

  // lane = row*NB*WT + block*WT + weight
  typedef struct packed {
    msg_t [LANES-1:0] lane;
  } msg_bus_t;

  // same lane order as msg_bus_t, D instead of message
  typedef struct packed {
    d_t [LANES-1:0] lane;
  } d_bus_t;

  //////////////////////////////
  // circulant order
  //////////////////////////////

  // one queue word, lane = weight*P + row
  typedef struct packed {
    d_t [CIRC_LANES-1:0] lane;
  } circ_word_t;

  // read request, entry = layer*SLOTS + addr
  typedef struct packed {
    logic              en;
    logic              layer;
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

endpackage

// ==== rtl/ldpc_dims_pkg.sv ====
package ldpc_dims_pkg;

  //////////////////////////////
  // decoder dimensions
  //////////////////////////////

  // rows handled per cycle
  localparam int P          = 4;
  // circulant blocks in one layer
  localparam int NB         = 4;
  // circulant weight
  localparam int WT         = 2;
  // slot addresses per layer
  localparam int SLOTS      = 4;
  // both layers live in the same queue
  localparam int LAYERS     = 2;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int ADDR_W     = 2;
  // signed extrinsic message
  localparam int MSG_W      = 8;
  // signed intermediate value D
  localparam int D_W        = 6;
  // one extra bit so new - old never wraps
  localparam int DIFF_W     = MSG_W + 1;

  // lane counts of the two bus orders
  localparam int LANES      = P * NB * WT;
  localparam int CIRC_LANES = P * WT;

  // queue covers the last write of every slot of both layers
  localparam int DEPTH      = LAYERS * SLOTS;
  localparam int IDX_W      = $clog2(DEPTH);

  // saturation limits of D, -32 .. +31
  localparam int D_MAX      = (2 ** (D_W - 1)) - 1;
  localparam int D_MIN      = -(2 ** (D_W - 1));

endpackage
